// File: verif/fm_timer_stim.txt
# Columns: command letter, then two hex fields, the second 0 where unused.
# W addr data, A or B latency, I irq_n, F flag_a flag_b, N idle clocks.
F 0 0
I 1 0
W 24 FA
W 25 00
W 26 FA
W 27 00
N 40 0
F 0 0
I 1 0
# Timer A with NA 1000, flag 1024 - 1000 + 1 clocks after ack.
W 27 01
A 19 0
I 1 0
W 27 05
I 0 0
W 27 15
F 0 0
I 1 0
# Overflows repeat every 24 clocks from the load, this one is 20 after the clear write.
A 14 0
I 0 0
W 27 14
F 0 0
I 1 0
N 40 0
F 0 0
# NA 1019 through both value registers, then NA 1020.
W 24 FE
W 25 03
W 27 01
A 06 0
W 27 10
F 0 0
W 24 FF
W 25 00
W 27 01
A 05 0
W 27 10
F 0 0
# Timer B with NB 250 and NB 255, 16 sub-steps per count.
W 27 02
B 61 0
I 1 0
W 27 0A
I 0 0
W 27 20
F 0 0
W 26 FF
W 27 02
B 11 0
W 27 20
F 0 0
I 1 0

// File: project.f
src/fm_timer_pkg.sv
src/fm_reg_port.sv
src/fm_timer.sv
src/fm_timer_pair.sv
src/fm_timer_top.sv
verif/fm_timer_tb.sv

// File: Makefile
# Verilator build and run of the FM timer testbench.
TOP := fm_timer_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: verif/fm_timer_tb.sv
// FM timer testbench that replays host writes from a stimulus file and checks flags and irq_n.
`timescale 1ns/1ps
`default_nettype none

module fm_timer_tb;

	logic       clk;
	logic       arst_n;
	logic       fast;
	logic       req;
	logic [7:0] addr;
	logic [7:0] wdata;
	wire        ack;
	wire        flag_a;
	wire        flag_b;
	wire        irq_n;

	integer errors;   // Failed checks so far.
	integer cyc;      // Rising clock edges since time zero.
	integer ack_cyc;  // Edge on which ack last rose.
	integer budget;   // Watchdog limit in clocks.
	byte    cmd_q[$]; // Command letters from the stimulus file.
	int     arg1_q[$];
	int     arg2_q[$];

	fm_timer_top dut0 (
		.clk    (clk),
		.arst_n (arst_n),
		.fast   (fast),
		.req    (req),
		.addr   (addr),
		.wdata  (wdata),
		.ack    (ack),
		.flag_a (flag_a),
		.flag_b (flag_b),
		.irq_n  (irq_n)
	);

	always #5 clk = ~clk;                  // 10 ns clock.
	always @(posedge clk) cyc <= cyc + 1;  // Edge counter for latencies.

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic check_val(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors = errors + 1;
			$display("[ERROR] %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	// Reads all commands up front so the watchdog knows the run length.
	task automatic load_stim();
		integer fd;
		integer n;
		string  line;
		byte    c;
		int     a;
		int     b;
		fd = $fopen("verif/fm_timer_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file verif/fm_timer_stim.txt");
			errors = errors + 1;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n    = $fgets(line, fd);
				a    = 0;
				b    = 0;
				if (line.len() >= 2 && line.getc(0) != "#") begin
					n = $sscanf(line, "%c %h %h", c, a, b);
					if (n < 2) begin
						$display("Malformed stimulus line: %s", line);
						errors = errors + 1;
					end else begin
						cmd_q.push_back(c);
						arg1_q.push_back(a);
						arg2_q.push_back(b);
						if (c == "A" || c == "B" || c == "N")
							budget = budget + a; // Expected latencies and idle waits.
					end
				end
			end
			$fclose(fd);
		end
		budget = budget + 2000;
	endtask

	// One complete four-phase write that may start as soon as ack is low.
	task automatic write_reg(input logic [7:0] a, input logic [7:0] d);
		int waited;
		check_val("ack", 0, ack); // No ack without a request.
		addr   = a;
		wdata  = d;
		req    = 1'b1;
		waited = 0;
		@(negedge clk);
		while (ack !== 1'b1 && waited < 8) begin
			@(negedge clk);
			waited = waited + 1;
		end
		if (ack !== 1'b1) begin
			$display("Handshake stalled at %0t ns, ack did not rise within 8 clocks", $time);
			errors = errors + 1;
		end
		ack_cyc = cyc;
		req     = 1'b0;
		waited  = 0;
		@(negedge clk);
		while (ack !== 1'b0 && waited < 8) begin
			@(negedge clk);
			waited = waited + 1;
		end
		if (ack !== 1'b0) begin
			$display("Handshake stalled at %0t ns, ack stayed high after req fell", $time);
			errors = errors + 1;
		end
	endtask

	// Waits for a flag and checks the clocks since the last ack rise.
	task automatic wait_flag(input logic sel_b, input int lat);
		int   waited;
		logic f;
		waited = 0;
		f      = sel_b ? flag_b : flag_a;
		while (f !== 1'b1 && waited < lat + 16) begin
			@(negedge clk);
			waited = waited + 1;
			f      = sel_b ? flag_b : flag_a;
		end
		if (f !== 1'b1) begin
			$display("%s never rose, waited %0d clocks up to %0t ns",
				sel_b ? "flag_b" : "flag_a", waited, $time);
			errors = errors + 1;
		end else begin
			check_val(sel_b ? "flag_b latency" : "flag_a latency", lat, cyc - ack_cyc);
		end
	endtask

	task automatic run_cmd(input byte c, input int a1, input int a2);
		case (c)
			"W": write_reg(a1[7:0], a2[7:0]);
			"A": wait_flag(1'b0, a1);
			"B": wait_flag(1'b1, a1);
			"I": check_val("irq_n", a1, irq_n);
			"F": begin
				check_val("flag_a", a1, flag_a);
				check_val("flag_b", a2, flag_b);
			end
			"N": repeat (a1) @(negedge clk);
			default: begin
				$display("Unknown stimulus command %c", c);
				errors = errors + 1;
			end
		endcase
	endtask

	task automatic finish_run();
		$display("Checks done with %0d errors", errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clk     = 1'b0;
		arst_n  = 1'b0;
		fast    = 1'b1;  // Test mode ticks on every clock.
		req     = 1'b0;
		addr    = 8'h00;
		wdata   = 8'h00;
		errors  = 0;
		cyc     = 0;
		ack_cyc = 0;
		budget  = 0;
		load_stim();
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		check_val("ack", 0, ack);
		foreach (cmd_q[i])
			run_cmd(cmd_q[i], arg1_q[i], arg2_q[i]);
		finish_run();
	end

	initial begin
		wait (budget > 0);
		repeat (budget) @(posedge clk);
		$display("Watchdog expired after %0d clocks, the test did not complete", budget);
		errors = errors + 1;
		finish_run();
	end

endmodule

`default_nettype wire

// File: src/fm_timer_top.sv
// FM timer block top level, joins the host write port to the timer pair.
`timescale 1ns/1ps
`default_nettype none

module fm_timer_top (
	input  wire        clk,
	input  wire        arst_n,
	input  wire        fast,
	input  wire        req,
	input  wire  [7:0] addr,
	input  wire  [7:0] wdata,
	output logic       ack,
	output logic       flag_a,
	output logic       flag_b,
	output logic       irq_n
);
	import fm_timer_pkg::*;

	logic [TA_W-1:0] val_a;   // Timer A reload value.
	logic [TB_W-1:0] val_b;   // Timer B reload value.
	logic            ien_a;   // Interrupt enables.
	logic            ien_b;
	logic            load_a;  // Start pulses.
	logic            load_b;
	logic            stop_a;  // Stop pulses.
	logic            stop_b;
	logic            clr_a;   // Flag clear pulses.
	logic            clr_b;

	fm_reg_port u_port (
		.clk    (clk),
		.arst_n (arst_n),
		.req    (req),
		.addr   (addr),
		.wdata  (wdata),
		.ack    (ack),
		.val_a  (val_a),
		.val_b  (val_b),
		.ien_a  (ien_a),
		.ien_b  (ien_b),
		.load_a (load_a),
		.load_b (load_b),
		.stop_a (stop_a),
		.stop_b (stop_b),
		.clr_a  (clr_a),
		.clr_b  (clr_b)
	);

	fm_timer_pair u_timers (
		.clk    (clk),
		.arst_n (arst_n),
		.fast   (fast),
		.val_a  (val_a),
		.val_b  (val_b),
		.load_a (load_a),
		.load_b (load_b),
		.stop_a (stop_a),
		.stop_b (stop_b),
		.clr_a  (clr_a),
		.clr_b  (clr_b),
		.ien_a  (ien_a),
		.ien_b  (ien_b),
		.flag_a (flag_a),
		.flag_b (flag_b),
		.irq_n  (irq_n)
	);

endmodule

`default_nettype wire

// File: src/fm_timer_pair.sv
// FM timer pair with tick prescaler, Timer A, Timer B and interrupt combining.
`timescale 1ns/1ps
`default_nettype none

module fm_timer_pair (
	input  wire                           clk,
	input  wire                           arst_n,
	input  wire                           fast,
	input  wire  [fm_timer_pkg::TA_W-1:0] val_a,
	input  wire  [fm_timer_pkg::TB_W-1:0] val_b,
	input  wire                           load_a,
	input  wire                           load_b,
	input  wire                           stop_a,
	input  wire                           stop_b,
	input  wire                           clr_a,
	input  wire                           clr_b,
	input  wire                           ien_a,
	input  wire                           ien_b,
	output logic                          flag_a,
	output logic                          flag_b,
	output logic                          irq_n
);
	import fm_timer_pkg::*;

	logic [PRE_W-1:0] pre_cnt;  // Clock divider for the timer tick.
	logic             pre_wrap; // Last clock of a tick period.
	logic             tick;     // Shared timer tick.

	////////////////////////////////////////////////////////////////////////////
	// Prescaler
	////////////////////////////////////////////////////////////////////////////

	assign pre_wrap = (pre_cnt == PRE_W'(TICK_DIV - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pre_cnt <= '0;
		end else if (pre_wrap) begin
			pre_cnt <= '0;
		end else begin
			pre_cnt <= pre_cnt + 1'b1;
		end
	end

	assign tick = fast | pre_wrap; // Test mode ticks on every clock.

	////////////////////////////////////////////////////////////////////////////
	// Timers
	////////////////////////////////////////////////////////////////////////////

	fm_timer #(.CNT_W(TA_W), .MULT_W(0)) timer_a (
		.clk         (clk),
		.arst_n      (arst_n),
		.tick        (tick),
		.start_value (val_a),
		.load        (load_a),
		.stop        (stop_a),
		.clr_flag    (clr_a),
		.flag        (flag_a)
	);

	fm_timer #(.CNT_W(TB_W), .MULT_W(TB_MULT_W)) timer_b (
		.clk         (clk),
		.arst_n      (arst_n),
		.tick        (tick),
		.start_value (val_b),
		.load        (load_b),
		.stop        (stop_b),
		.clr_flag    (clr_b),
		.flag        (flag_b)
	);

	// Active low, any enabled flag pulls it down.
	assign irq_n = ~((flag_a & ien_a) | (flag_b & ien_b));

endmodule

`default_nettype wire

// File: src/fm_timer.sv
// FM timer counter, counts up to overflow with optional multiplier and sticky flag.
`timescale 1ns/1ps
`default_nettype none

module fm_timer #(
	parameter int CNT_W  = 10, // Visible counter width.
	parameter int MULT_W = 0   // Sub-step bits below the counter, 0 for none.
) (
	input  wire              clk,
	input  wire              arst_n,
	input  wire              tick,
	input  wire  [CNT_W-1:0] start_value,
	input  wire              load,
	input  wire              stop,
	input  wire              clr_flag,
	output logic             flag
);

	logic                    run;  // Timer is counting.
	logic [CNT_W+MULT_W-1:0] cnt;  // Counter with multiplier in the low bits.
	logic [CNT_W+MULT_W-1:0] nxt;  // Counter plus one.
	logic [CNT_W+MULT_W-1:0] init; // Reload value, multiplier cleared.
	logic                    ovf;  // Carry out of the whole register.
	logic                    step; // Count on this edge.

	////////////////////////////////////////////////////////////////////////////
	// Next-count logic
	////////////////////////////////////////////////////////////////////////////

	// Start value goes in the top bits, multiplier starts from zero.
	assign init = (CNT_W+MULT_W)'(start_value) << MULT_W;

	// Multiplier carries into the counter, counter carry is the overflow.
	assign {ovf, nxt} = {1'b0, cnt} + 1'b1;

	assign step = run && tick;

	////////////////////////////////////////////////////////////////////////////
	// State
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			run <= 1'b0;
		end else if (load) begin
			run <= 1'b1; // Load also starts the timer.
		end else if (stop) begin
			run <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= init;
		end else if (step) begin
			cnt <= ovf ? init : nxt; // Reload and keep going on overflow.
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flag <= 1'b0;
		end else if (clr_flag) begin
			flag <= 1'b0; // Clear beats a same-cycle overflow.
		end else if (step && ovf) begin
			flag <= 1'b1;
		end
	end

	// A stopped timer holds its count until the next load.
	cnt_held_when_stopped: assert property (@(posedge clk) disable iff (!arst_n)
		(!run && !load) |=> $stable(cnt));

endmodule

`default_nettype wire

// File: src/fm_reg_port.sv
// FM timer write port that runs the four-phase handshake and decodes register writes.
`timescale 1ns/1ps
`default_nettype none

module fm_reg_port (
	input  wire                           clk,
	input  wire                           arst_n,
	input  wire                           req,
	input  wire  [7:0]                    addr,
	input  wire  [7:0]                    wdata,
	output logic                          ack,
	output logic [fm_timer_pkg::TA_W-1:0] val_a,
	output logic [fm_timer_pkg::TB_W-1:0] val_b,
	output logic                          ien_a,
	output logic                          ien_b,
	output logic                          load_a,
	output logic                          load_b,
	output logic                          stop_a,
	output logic                          stop_b,
	output logic                          clr_a,
	output logic                          clr_b
);
	import fm_timer_pkg::*;

	port_state_t state;     // Handshake state.
	logic        wr;        // Write accepted on this edge.
	logic        run_a_q;   // Run bits of the last control write.
	logic        run_b_q;
	logic        run_a_new; // Run bits of the current write.
	logic        run_b_new;

	assign wr        = (state == IDLE) && req;  // One write per handshake.
	assign run_a_new = wdata[CTRL_RUN_A];
	assign run_b_new = wdata[CTRL_RUN_B];

	////////////////////////////////////////////////////////////////////////////
	// Handshake
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			ack   <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (req) begin
						state <= ACK;  // Write lands on this edge.
						ack   <= 1'b1;
					end
				end
				ACK: begin
					if (!req) begin
						state <= WAIT_LOW; // Host released so ack drops.
						ack   <= 1'b0;
					end
				end
				WAIT_LOW: begin
					state <= IDLE; // A new req may already be up.
				end
				default: begin
					state <= IDLE;
					ack   <= 1'b0;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Register decode
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			val_a   <= '0;
			val_b   <= '0;
			ien_a   <= 1'b0;
			ien_b   <= 1'b0;
			run_a_q <= 1'b0;
			run_b_q <= 1'b0;
			load_a  <= 1'b0;
			load_b  <= 1'b0;
			stop_a  <= 1'b0;
			stop_b  <= 1'b0;
			clr_a   <= 1'b0;
			clr_b   <= 1'b0;
		end else begin
			load_a <= 1'b0; // Pulses last one cycle.
			load_b <= 1'b0;
			stop_a <= 1'b0;
			stop_b <= 1'b0;
			clr_a  <= 1'b0;
			clr_b  <= 1'b0;
			if (wr) begin
				case (addr)
					ADDR_TA_HI: val_a[TA_W-1:2] <= wdata; // Upper eight bits.
					ADDR_TA_LO: val_a[1:0]      <= wdata[1:0];
					ADDR_TB:    val_b           <= wdata;
					ADDR_CTRL: begin
						ien_a   <= wdata[CTRL_IEN_A];
						ien_b   <= wdata[CTRL_IEN_B];
						load_a  <= run_a_new & ~run_a_q; // Start on rising run bit.
						load_b  <= run_b_new & ~run_b_q;
						stop_a  <= ~run_a_new & run_a_q; // Stop on falling run bit.
						stop_b  <= ~run_b_new & run_b_q;
						clr_a   <= wdata[CTRL_CLR_A];
						clr_b   <= wdata[CTRL_CLR_B];
						run_a_q <= run_a_new;
						run_b_q <= run_b_new;
					end
					default: ; // Other addresses belong to the FM core.
				endcase
			end
		end
	end

	// ack is only ever an answer to a request seen on the edge before.
	ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ack) |-> $past(req));

endmodule

`default_nettype wire

// File: src/fm_timer_pkg.sv
// FM timer package with register addresses, control bits, widths and port state type.
`default_nettype none

package fm_timer_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Register map
	////////////////////////////////////////////////////////////////////////////

	// Timer registers sit in the global part of the FM register map.
	localparam logic [7:0] ADDR_TA_HI = 8'h24; // Timer A value bits 9:2.
	localparam logic [7:0] ADDR_TA_LO = 8'h25; // Timer A value bits 1:0.
	localparam logic [7:0] ADDR_TB    = 8'h26; // Timer B value.
	localparam logic [7:0] ADDR_CTRL  = 8'h27; // Run, enable and clear bits.

	////////////////////////////////////////////////////////////////////////////
	// Control byte layout
	////////////////////////////////////////////////////////////////////////////

	localparam int CTRL_RUN_A = 0; // Timer A run where 0 to 1 loads and starts.
	localparam int CTRL_RUN_B = 1; // Timer B run.
	localparam int CTRL_IEN_A = 2; // Timer A interrupt enable.
	localparam int CTRL_IEN_B = 3; // Timer B interrupt enable.
	localparam int CTRL_CLR_A = 4; // Writing 1 clears flag A.
	localparam int CTRL_CLR_B = 5; // Writing 1 clears flag B.

	////////////////////////////////////////////////////////////////////////////
	// Counter sizes and prescaler
	////////////////////////////////////////////////////////////////////////////

	localparam int TA_W      = 10; // Timer A counter width.
	localparam int TB_W      = 8;  // Timer B counter width.
	localparam int TB_MULT_W = 4;  // Timer B runs 16 sub-steps per count.

	// Timer tick rate in normal mode.
	localparam int TICK_DIV  = 24;               // Clocks per timer tick.
	localparam int PRE_W     = $clog2(TICK_DIV); // Prescaler counter width.

	////////////////////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////////////////////

	// Write port handshake states.
	typedef enum logic [1:0] {
		IDLE     = 2'd0, // Waiting for req.
		ACK      = 2'd1, // Write done and ack held until req drops.
		WAIT_LOW = 2'd2  // ack low for one cycle before rearming.
	} port_state_t;

endpackage

`default_nettype wire
